// ==== logic/cpu_pkg.sv ====
package cpu_pkg;

    typedef logic [15:0] word_t;
    typedef logic [1:0]  reg_idx_t;

    // Instruction word layout.
    //   [15:12] opcode, [11:10] rs, [9:8] rt
    //   ALU_R:  [7:6] rd, [5:0] funct
    //   others: [7:0] imm, destination is rt
    //   JMP:    [11:0] target within the current 4K page
    typedef enum logic [3:0] {
        OP_BNE   = 4'd0,
        OP_BEQ   = 4'd1,
        OP_ADI   = 4'd4,
        OP_ORI   = 4'd5,
        OP_LHI   = 4'd6,
        OP_LWD   = 4'd7,
        OP_SWD   = 4'd8,
        OP_JMP   = 4'd9,
        OP_HLT   = 4'd11,
        OP_ALU_R = 4'd15
    } opcode_e;

    // ALU_R funct values 0 to 4 select the first five operations directly.
    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_SUB  = 3'd1,
        ALU_AND  = 3'd2,
        ALU_ORR  = 3'd3,
        ALU_NOT  = 3'd4,
        ALU_LHI  = 3'd5,
        ALU_PASS = 3'd6
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC_REG      = 2'd0, // Read data 2.
        SRC_SIGN_IMM = 2'd1,
        SRC_ZERO_IMM = 2'd2
    } src_b_e;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        word_t    r_data1;
        word_t    r_data2;
        word_t    imm;        // Sign extended.
        opcode_e  opcode;
        reg_idx_t rd;
        alu_op_e  alu_op;
        src_b_e   src_b;
        logic     mem_read;
        logic     mem_write;
        logic     branch;
        logic     reg_write;
        logic     mem_to_reg;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        word_t    alu_result;
        word_t    store_data;
        reg_idx_t rd;
        logic     mem_read;
        logic     mem_write;
        logic     reg_write;
        logic     mem_to_reg;
        logic     halt;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    wb_data;
        logic     reg_write;
        logic     halt;       // Sticky once HLT retires.
    } mem_wb_t;

endpackage

// ==== logic/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage import cpu_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic   Clk,
    input  logic   rst,
    input  logic   stall,
    input  logic   halt_fetch,
    input  logic   jump_taken,
    input  word_t  jump_target,
    input  logic   branch_taken,
    input  word_t  branch_target,
    output word_t  imem_addr,
    input  word_t  imem_data,
    output if_id_t if_id
);

    word_t  pc;
    word_t  pc_next;
    if_id_t if_id_next;

    assign imem_addr = pc;

    always_comb begin
        pc_next          = pc + 16'd1;
        if_id_next.valid = 1'b1;
        if_id_next.pc    = pc;
        if_id_next.instr = imem_data;

        if (branch_taken) begin
            pc_next          = branch_target; // Both younger slots are wrong path.
            if_id_next.valid = 1'b0;
        end else if (jump_taken) begin
            pc_next          = jump_target;
            if_id_next.valid = 1'b0;
        end else if (stall) begin
            pc_next    = pc;
            if_id_next = if_id;
        end else if (halt_fetch) begin
            pc_next          = pc;
            if_id_next.valid = 1'b0;
        end
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge Clk) begin
        if_id <= if_id_next;
        if (rst) begin
            if_id.valid <= 1'b0;
        end
    end

endmodule

// ==== logic/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage import cpu_pkg::*; (
    input  logic    Clk,
    input  logic    rst,
    input  if_id_t  if_id,
    input  ex_mem_t ex_mem,
    input  mem_wb_t mem_wb,
    input  logic    branch_taken,
    output logic    stall,
    output logic    halt_fetch,
    output logic    jump_taken,
    output word_t   jump_target,
    output id_ex_t  id_ex
);

    word_t    rf [0:3];
    opcode_e  opcode;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t rd_field;
    logic [5:0] funct;
    logic [7:0] imm8;

    alu_op_e  alu_op;
    src_b_e   src_b;
    reg_idx_t dest;
    logic     mem_read;
    logic     mem_write;
    logic     branch;
    logic     reg_write;
    logic     mem_to_reg;
    logic     uses_rs;
    logic     uses_rt;
    logic     is_jmp;
    logic     is_hlt;

    word_t    rdata1;
    word_t    rdata2;
    logic     busy_rs;
    logic     busy_rt;
    logic     halt_seen;
    id_ex_t   id_ex_next;

    assign opcode   = opcode_e'(if_id.instr[15:12]);
    assign rs       = if_id.instr[11:10];
    assign rt       = if_id.instr[9:8];
    assign rd_field = if_id.instr[7:6];
    assign funct    = if_id.instr[5:0];
    assign imm8     = if_id.instr[7:0];

    always_comb begin
        alu_op     = ALU_PASS;
        src_b      = SRC_REG;
        dest       = rt;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        branch     = 1'b0;
        reg_write  = 1'b0;
        mem_to_reg = 1'b0;
        uses_rs    = 1'b0;
        uses_rt    = 1'b0;
        is_jmp     = 1'b0;
        is_hlt     = 1'b0;

        case (opcode)
            OP_ALU_R: begin
                dest = rd_field;
                if (funct <= 6'd4) begin // Other funct codes fall through as no-ops.
                    alu_op    = alu_op_e'(funct[2:0]);
                    reg_write = 1'b1;
                    uses_rs   = 1'b1;
                    uses_rt   = (alu_op != ALU_NOT);
                end
            end
            OP_ADI: begin
                alu_op    = ALU_ADD;
                src_b     = SRC_SIGN_IMM;
                reg_write = 1'b1;
                uses_rs   = 1'b1;
            end
            OP_ORI: begin
                alu_op    = ALU_ORR;
                src_b     = SRC_ZERO_IMM;
                reg_write = 1'b1;
                uses_rs   = 1'b1;
            end
            OP_LHI: begin
                alu_op    = ALU_LHI;
                src_b     = SRC_ZERO_IMM;
                reg_write = 1'b1;
            end
            OP_LWD: begin
                alu_op     = ALU_ADD;
                src_b      = SRC_SIGN_IMM;
                mem_read   = 1'b1;
                reg_write  = 1'b1;
                mem_to_reg = 1'b1;
                uses_rs    = 1'b1;
            end
            OP_SWD: begin
                alu_op    = ALU_ADD;
                src_b     = SRC_SIGN_IMM;
                mem_write = 1'b1;
                uses_rs   = 1'b1;
                uses_rt   = 1'b1; // Store data.
            end
            OP_BNE, OP_BEQ: begin
                branch  = 1'b1;
                uses_rs = 1'b1;
                uses_rt = 1'b1;
            end
            OP_JMP: is_jmp = 1'b1;
            OP_HLT: is_hlt = 1'b1;
            default: ;
        endcase
    end

    // Register file reads see the value retiring this cycle.
    assign rdata1 = (mem_wb.valid && mem_wb.reg_write && mem_wb.rd == rs) ?
                    mem_wb.wb_data : rf[rs];
    assign rdata2 = (mem_wb.valid && mem_wb.reg_write && mem_wb.rd == rt) ?
                    mem_wb.wb_data : rf[rt];

    assign busy_rs = (id_ex.valid && id_ex.reg_write && id_ex.rd == rs) ||
                     (ex_mem.valid && ex_mem.reg_write && ex_mem.rd == rs);
    assign busy_rt = (id_ex.valid && id_ex.reg_write && id_ex.rd == rt) ||
                     (ex_mem.valid && ex_mem.reg_write && ex_mem.rd == rt);

    assign stall = if_id.valid && ((uses_rs && busy_rs) || (uses_rt && busy_rt));

    assign jump_taken  = if_id.valid && is_jmp && !branch_taken;
    assign jump_target = {if_id.pc[15:12], if_id.instr[11:0]};

    // A HLT behind a taken branch is wrong path and must not stop fetch.
    assign halt_fetch = halt_seen || (if_id.valid && is_hlt && !branch_taken);

    always_comb begin
        id_ex_next.valid      = if_id.valid && !stall && !branch_taken;
        id_ex_next.pc         = if_id.pc;
        id_ex_next.r_data1    = rdata1;
        id_ex_next.r_data2    = rdata2;
        id_ex_next.imm        = {{8{imm8[7]}}, imm8};
        id_ex_next.opcode     = opcode;
        id_ex_next.rd         = dest;
        id_ex_next.alu_op     = alu_op;
        id_ex_next.src_b      = src_b;
        id_ex_next.mem_read   = mem_read;
        id_ex_next.mem_write  = mem_write;
        id_ex_next.branch     = branch;
        id_ex_next.reg_write  = reg_write;
        id_ex_next.mem_to_reg = mem_to_reg;
    end

    always_ff @(posedge Clk) begin
        id_ex <= id_ex_next;
        if (rst) begin
            id_ex.valid <= 1'b0;
        end
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            halt_seen <= 1'b0;
        end else if (halt_fetch) begin
            halt_seen <= 1'b1;
        end
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                rf[i] <= '0;
            end
        end else if (mem_wb.valid && mem_wb.reg_write) begin
            rf[mem_wb.rd] <= mem_wb.wb_data;
        end
    end

endmodule

// ==== logic/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage import cpu_pkg::*; (
    input  logic    Clk,
    input  logic    rst,
    input  id_ex_t  id_ex,
    output logic    branch_taken,
    output word_t   branch_target,
    output ex_mem_t ex_mem
);

    word_t   operand_b;
    word_t   alu_result;
    logic    operands_equal;
    logic    branch_cond;
    ex_mem_t ex_mem_next;

    always_comb begin
        case (id_ex.src_b)
            SRC_REG:      operand_b = id_ex.r_data2;
            SRC_SIGN_IMM: operand_b = id_ex.imm;
            SRC_ZERO_IMM: operand_b = {8'h00, id_ex.imm[7:0]};
            default:      operand_b = id_ex.r_data2;
        endcase
    end

    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD:  alu_result = id_ex.r_data1 + operand_b;
            ALU_SUB:  alu_result = id_ex.r_data1 - operand_b;
            ALU_AND:  alu_result = id_ex.r_data1 & operand_b;
            ALU_ORR:  alu_result = id_ex.r_data1 | operand_b;
            ALU_NOT:  alu_result = ~id_ex.r_data1;
            ALU_LHI:  alu_result = {operand_b[7:0], 8'h00};
            ALU_PASS: alu_result = operand_b;
            default:  alu_result = operand_b;
        endcase
    end

    assign operands_equal = (id_ex.r_data1 == id_ex.r_data2);

    // BEQ takes on equal, BNE on not equal.
    assign branch_cond   = (id_ex.opcode == OP_BEQ) ? operands_equal : !operands_equal;
    assign branch_taken  = id_ex.valid && id_ex.branch && branch_cond;
    assign branch_target = id_ex.pc + 16'd1 + id_ex.imm;

    always_comb begin
        ex_mem_next.valid      = id_ex.valid;
        ex_mem_next.alu_result = alu_result;
        ex_mem_next.store_data = id_ex.r_data2;
        ex_mem_next.rd         = id_ex.rd;
        ex_mem_next.mem_read   = id_ex.mem_read;
        ex_mem_next.mem_write  = id_ex.mem_write;
        ex_mem_next.reg_write  = id_ex.reg_write;
        ex_mem_next.mem_to_reg = id_ex.mem_to_reg;
        ex_mem_next.halt       = (id_ex.opcode == OP_HLT);
    end

    always_ff @(posedge Clk) begin
        ex_mem <= ex_mem_next;
        if (rst) begin
            ex_mem.valid <= 1'b0;
        end
    end

endmodule

// ==== logic/memory_stage.sv ====
`timescale 1ns/1ps

module memory_stage import cpu_pkg::*; (
    input  logic    Clk,
    input  logic    rst,
    input  ex_mem_t ex_mem,
    output word_t   dmem_addr,
    output word_t   dmem_wdata,
    output logic    dmem_write,
    output logic    dmem_read,
    input  word_t   dmem_rdata,
    output mem_wb_t mem_wb
);

    mem_wb_t mem_wb_next;

    assign dmem_addr  = ex_mem.alu_result;
    assign dmem_wdata = ex_mem.store_data;
    assign dmem_write = ex_mem.valid && ex_mem.mem_write;
    assign dmem_read  = ex_mem.valid && ex_mem.mem_read;

    always_comb begin
        mem_wb_next.valid     = ex_mem.valid;
        mem_wb_next.rd        = ex_mem.rd;
        mem_wb_next.wb_data   = ex_mem.mem_to_reg ? dmem_rdata : ex_mem.alu_result;
        mem_wb_next.reg_write = ex_mem.reg_write;
        mem_wb_next.halt      = mem_wb.halt || (ex_mem.valid && ex_mem.halt);
    end

    always_ff @(posedge Clk) begin
        mem_wb <= mem_wb_next;
        if (rst) begin
            mem_wb.valid <= 1'b0;
            mem_wb.halt  <= 1'b0;
        end
    end

endmodule

// ==== logic/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic     Clk,
    input  logic     rst,
    output word_t    imem_addr,
    input  word_t    imem_data,
    output word_t    dmem_addr,
    output word_t    dmem_wdata,
    output logic     dmem_write,
    output logic     dmem_read,
    input  word_t    dmem_rdata,
    output logic     wb_valid,
    output reg_idx_t wb_reg,
    output word_t    wb_data,
    output logic     halted
);

    if_id_t  if_id;
    id_ex_t  id_ex;
    ex_mem_t ex_mem;
    mem_wb_t mem_wb;
    logic    stall;
    logic    halt_fetch;
    logic    jump_taken;
    word_t   jump_target;
    logic    branch_taken;
    word_t   branch_target;

    fetch_stage #(
        .RESET_PC(RESET_PC)
    ) fetch_i (
        .Clk(Clk),
        .rst(rst),
        .stall(stall),
        .halt_fetch(halt_fetch),
        .jump_taken(jump_taken),
        .jump_target(jump_target),
        .branch_taken(branch_taken),
        .branch_target(branch_target),
        .imem_addr(imem_addr),
        .imem_data(imem_data),
        .if_id(if_id)
    );

    decode_stage decode_i (
        .Clk(Clk),
        .rst(rst),
        .if_id(if_id),
        .ex_mem(ex_mem),
        .mem_wb(mem_wb),
        .branch_taken(branch_taken),
        .stall(stall),
        .halt_fetch(halt_fetch),
        .jump_taken(jump_taken),
        .jump_target(jump_target),
        .id_ex(id_ex)
    );

    execute_stage execute_i (
        .Clk(Clk),
        .rst(rst),
        .id_ex(id_ex),
        .branch_taken(branch_taken),
        .branch_target(branch_target),
        .ex_mem(ex_mem)
    );

    memory_stage memory_i (
        .Clk(Clk),
        .rst(rst),
        .ex_mem(ex_mem),
        .dmem_addr(dmem_addr),
        .dmem_wdata(dmem_wdata),
        .dmem_write(dmem_write),
        .dmem_read(dmem_read),
        .dmem_rdata(dmem_rdata),
        .mem_wb(mem_wb)
    );

    assign wb_valid = mem_wb.valid && mem_wb.reg_write; // Register file write strobe.
    assign wb_reg   = mem_wb.rd;
    assign wb_data  = mem_wb.wb_data;
    assign halted   = mem_wb.halt;

endmodule

// ==== verification/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb import cpu_pkg::*; ();

    localparam word_t RESET_PC = 16'h0000;

    typedef struct packed {
        reg_idx_t rd;
        word_t    data;
    } wb_entry_t;

    typedef struct packed {
        word_t addr;
        word_t data;
    } st_entry_t;

    logic     Clk = 1'b0;
    logic     rst;
    word_t    imem_addr;
    word_t    imem_data;
    word_t    dmem_addr;
    word_t    dmem_wdata;
    logic     dmem_write;
    logic     dmem_read;
    word_t    dmem_rdata;
    logic     wb_valid;
    reg_idx_t wb_reg;
    word_t    wb_data;
    logic     halted;

    word_t       imem [0:255];
    word_t       dmem [0:255];
    word_t       model_regs [0:3];
    word_t       model_mem [0:255];
    wb_entry_t   exp_wb [$];
    st_entry_t   exp_st [$];
    logic [31:0] rng_state = 32'he3da_5555;
    word_t       emit_addr;
    int          prog_len = 0;
    int          wb_errors = 0;
    int          st_errors = 0;
    int          ctl_errors = 0;
    logic        reset_tail_done = 1'b0;
    logic        halt_seen = 1'b0;

    cpu_top #(
        .RESET_PC(RESET_PC)
    ) dut_i (
        .Clk(Clk),
        .rst(rst),
        .imem_addr(imem_addr),
        .imem_data(imem_data),
        .dmem_addr(dmem_addr),
        .dmem_wdata(dmem_wdata),
        .dmem_write(dmem_write),
        .dmem_read(dmem_read),
        .dmem_rdata(dmem_rdata),
        .wb_valid(wb_valid),
        .wb_reg(wb_reg),
        .wb_data(wb_data),
        .halted(halted)
    );

    always #50 Clk = ~Clk;

    assign imem_data  = imem[imem_addr[7:0]]; // Both memories read combinationally.
    assign dmem_rdata = dmem_read ? dmem[dmem_addr[7:0]] : '0;

    always @(posedge Clk) begin
        if (dmem_write) begin
            dmem[dmem_addr[7:0]] <= dmem_wdata;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic word_t fill_word(input int unsigned i);
        return word_t'((i * 32'h9e37) ^ 32'h5a5a);
    endfunction

    function automatic word_t enc_r(input alu_op_e fn, input reg_idx_t rs, input reg_idx_t rt,
                                    input reg_idx_t rd);
        return {OP_ALU_R, rs, rt, rd, 3'b000, fn};
    endfunction

    function automatic word_t enc_i(input opcode_e op, input reg_idx_t rs, input reg_idx_t rt,
                                    input logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic emit(input word_t w);
        imem[emit_addr[7:0]] = w;
        emit_addr = emit_addr + 16'd1;
        prog_len++;
    endtask

    task automatic build_program();
        logic [31:0] r;
        for (int i = 0; i < 256; i++) begin
            imem[i] = {OP_HLT, 4'h0, 8'(i)}; // Anything fetched outside the program halts.
            dmem[i] = fill_word(i);
        end
        emit_addr = RESET_PC;
        emit(enc_i(OP_LHI, 2'd0, 2'd1, 8'h12));
        emit(enc_i(OP_ORI, 2'd1, 2'd1, 8'h34));
        emit(enc_i(OP_ADI, 2'd0, 2'd2, 8'h05));
        emit(enc_r(ALU_ADD, 2'd1, 2'd2, 2'd3));
        emit(enc_r(ALU_SUB, 2'd3, 2'd1, 2'd0));
        for (int k = 0; k < 20; k++) begin
            rng_state = xorshift32(rng_state);
            r = rng_state;
            case (r[2:0])
                3'd5:    emit(enc_i(OP_ADI, r[4:3], r[6:5], r[16:9]));
                3'd6:    emit(enc_i(OP_ORI, r[4:3], r[6:5], r[16:9]));
                3'd7:    emit(enc_i(OP_LHI, r[4:3], r[6:5], r[16:9]));
                default: emit(enc_r(alu_op_e'(r[2:0]), r[4:3], r[6:5], r[8:7]));
            endcase
        end
        emit(enc_i(OP_LHI, 2'd0, 2'd0, 8'h00));
        emit(enc_i(OP_ORI, 2'd0, 2'd0, 8'h20));
        emit(enc_i(OP_SWD, 2'd0, 2'd3, 8'h03));
        emit(enc_i(OP_SWD, 2'd0, 2'd1, 8'hff));
        emit(enc_i(OP_LWD, 2'd0, 2'd2, 8'h03));
        emit(enc_i(OP_LWD, 2'd0, 2'd1, 8'hff));
        emit(enc_r(ALU_ADD, 2'd2, 2'd1, 2'd3));
        emit(enc_i(OP_BEQ, 2'd2, 2'd2, 8'h02));
        emit(enc_i(OP_SWD, 2'd0, 2'd3, 8'h05)); // Wrong path.
        emit(enc_i(OP_ADI, 2'd1, 2'd1, 8'h01));
        emit(enc_i(OP_BNE, 2'd1, 2'd1, 8'h01));
        emit(enc_i(OP_ADI, 2'd3, 2'd3, 8'h07));
        emit(enc_i(OP_LHI, 2'd0, 2'd2, 8'h55));
        emit(enc_i(OP_BNE, 2'd2, 2'd0, 8'h01));
        emit(enc_i(OP_ADI, 2'd0, 2'd0, 8'h09));
        emit(enc_i(OP_BEQ, 2'd0, 2'd2, 8'h01));
        emit({OP_JMP, 12'(emit_addr + 16'd2)});
        emit(enc_i(OP_ADI, 2'd1, 2'd1, 8'h03));
        emit(enc_r(ALU_NOT, 2'd3, 2'd0, 2'd1));
        emit(16'h2f0f); // Unused opcode.
        emit(enc_i(OP_BEQ, 2'd1, 2'd1, 8'h02));
        emit({OP_HLT, 12'h000}); // HLT behind a taken branch.
        emit({OP_HLT, 12'h000});
        emit({OP_HLT, 12'h000});
    endtask

    task automatic model_write(input reg_idx_t rd, input word_t v);
        wb_entry_t e;
        model_regs[rd] = v;
        e.rd = rd;
        e.data = v;
        exp_wb.push_back(e);
    endtask

    task automatic run_model();
        word_t     pc;
        word_t     instr;
        word_t     a;
        word_t     b;
        word_t     simm;
        word_t     next_pc;
        word_t     addr;
        logic      done;
        int        steps;
        st_entry_t s;
        for (int i = 0; i < 256; i++) begin
            model_mem[i] = fill_word(i);
        end
        for (int i = 0; i < 4; i++) begin
            model_regs[i] = '0;
        end
        pc = RESET_PC;
        done = 1'b0;
        steps = 0;
        while (!done && steps < 1000) begin
            instr   = imem[pc[7:0]];
            a       = model_regs[instr[11:10]];
            b       = model_regs[instr[9:8]];
            simm    = {{8{instr[7]}}, instr[7:0]};
            addr    = a + simm;
            next_pc = pc + 16'd1;
            case (instr[15:12])
                OP_ALU_R: begin
                    case (instr[5:0])
                        6'd0:    model_write(instr[7:6], a + b);
                        6'd1:    model_write(instr[7:6], a - b);
                        6'd2:    model_write(instr[7:6], a & b);
                        6'd3:    model_write(instr[7:6], a | b);
                        6'd4:    model_write(instr[7:6], ~a);
                        default: ;
                    endcase
                end
                OP_ADI: model_write(instr[9:8], a + simm);
                OP_ORI: model_write(instr[9:8], a | {8'h00, instr[7:0]});
                OP_LHI: model_write(instr[9:8], {instr[7:0], 8'h00});
                OP_LWD: model_write(instr[9:8], model_mem[addr[7:0]]);
                OP_SWD: begin
                    model_mem[addr[7:0]] = b;
                    s.addr = addr;
                    s.data = b;
                    exp_st.push_back(s);
                end
                OP_BEQ: if (a == b) next_pc = pc + 16'd1 + simm;
                OP_BNE: if (a != b) next_pc = pc + 16'd1 + simm;
                OP_JMP: next_pc = {pc[15:12], instr[11:0]};
                OP_HLT: done = 1'b1;
                default: ;
            endcase
            pc = next_pc;
            steps++;
        end
        if (!done) begin
            ctl_errors++;
            $display("reference model did not reach HLT within %0d steps", steps);
        end
    endtask

    task automatic report_and_finish();
        $display("errors: writeback %0d, store %0d, control %0d",
                 wb_errors, st_errors, ctl_errors);
        if (wb_errors + st_errors + ctl_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    always @(negedge Clk) begin : check_events
        wb_entry_t ew;
        st_entry_t es;
        if (rst || !reset_tail_done) begin
            assert (!wb_valid && !dmem_write && !dmem_read && !halted && imem_addr == RESET_PC)
            else begin
                ctl_errors++;
                $display("error at %0t: active output or imem_addr %h around reset",
                         $time, imem_addr);
            end
            reset_tail_done = !rst;
        end
        if (halt_seen) begin
            assert (halted && !wb_valid && !dmem_write) else begin
                ctl_errors++;
                $display("halted fell, or a writeback or store happened after halt");
            end
        end
        if (wb_valid) begin
            assert (exp_wb.size() != 0) else begin
                ctl_errors++;
                $display("writeback to r%0d with no writeback left to expect", wb_reg);
            end
            if (exp_wb.size() != 0) begin
                ew = exp_wb.pop_front();
                assert (wb_reg == ew.rd && wb_data == ew.data) else begin
                    wb_errors++;
                    $display("error at %0t: writeback r%0d = %h, expected r%0d = %h",
                             $time, wb_reg, wb_data, ew.rd, ew.data);
                end
            end
        end
        if (dmem_write) begin
            assert (exp_st.size() != 0) else begin
                ctl_errors++;
                $display("store to %h with no store left to expect", dmem_addr);
            end
            if (exp_st.size() != 0) begin
                es = exp_st.pop_front();
                assert (dmem_addr == es.addr && dmem_wdata == es.data) else begin
                    st_errors++;
                    $display("error at %0t: store [%h] = %h, expected [%h] = %h",
                             $time, dmem_addr, dmem_wdata, es.addr, es.data);
                end
            end
        end
        if (halted && !halt_seen) begin
            assert (exp_wb.size() == 0 && exp_st.size() == 0) else begin
                ctl_errors++;
                $display("halted with %0d writebacks and %0d stores never seen",
                         exp_wb.size(), exp_st.size());
            end
            halt_seen = 1'b1;
        end
    end

    initial begin
        rst = 1'b1;
        build_program();
        run_model();
        repeat (16) @(posedge Clk);
        rst <= 1'b0;
        wait (halt_seen);
        repeat (8) @(posedge Clk); // Halted must hold with no further activity.
        report_and_finish();
    end

    initial begin : watchdog
        wait (prog_len > 0);
        repeat (16 + 8 * prog_len) @(posedge Clk);
        ctl_errors++;
        $display("timeout after %0d cycles, halted never rose", 16 + 8 * prog_len);
        report_and_finish();
    end

endmodule

// ==== project.f ====
logic/cpu_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/cpu_top.sv
verification/cpu_tb.sv

// ==== Makefile ====
SRCS := $(shell cat project.f)

.PHONY: run clean

run: obj_dir/Vcpu_tb
	@out=$$(./obj_dir/Vcpu_tb); echo "$$out"; echo "$$out" | grep -q '^TEST RESULT: PASS$$'

obj_dir/Vcpu_tb: project.f $(SRCS)
	verilator --binary --timing --assert -f project.f --top-module cpu_tb

clean:
	rm -rf obj_dir
